//--- source/sram_params.svh
`ifndef SRAM_PARAMS_SVH
`define SRAM_PARAMS_SVH

// ####################
// system timing
// ####################

// system clock frequency in Hz that sets the length of one SRAM transaction
`define SRAM_CLOCK_HZ 100_000_000

// ####################
// SRAM geometry
// ####################

`define SRAM_ADDR_WIDTH 18 // half-word address bits on the SRAM pins

// ####################
// requesters
// ####################

`define SRAM_NUM_PORTS 2 // instruction port and data port

`endif

//--- source/sram_pkg.sv
`default_nettype none

package sram_pkg;

	// ####################
	// request payload
	// ####################

	// one 32-bit word access that the controller splits into two half-word cycles
	typedef struct packed {
		logic rw;             // 1 = write
		logic [31:0] address; // byte address with bits 1:0 ignored
		logic [31:0] wdata;
		logic [3:0] be;       // byte n enabled by bit n and ignored by reads
	} sram_req_t;

	// ####################
	// response payload
	// ####################

	typedef struct packed {
		logic [31:0] rdata; // valid in the ready cycle of a read
	} sram_rsp_t;

endpackage

`default_nettype wire

//--- source/sram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

// round-robin arbiter between peer requesters sharing one SRAM controller
// a grant is held for one whole transaction and then released for one idle cycle
module sram_arbiter #(
	parameter int N_PORTS = 2
)(
	input wire i_clock,
	input wire i_reset,

	// requester side
	input wire [N_PORTS-1:0] i_request,
	input wire sram_pkg::sram_req_t [N_PORTS-1:0] i_req,
	output logic [N_PORTS-1:0] o_ready,
	output sram_pkg::sram_rsp_t o_rsp,

	// controller side
	output logic o_mem_request,
	output sram_pkg::sram_req_t o_mem_req,
	input wire i_mem_ready,
	input wire sram_pkg::sram_rsp_t i_mem_rsp
);

	localparam int IDX_W = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

	logic busy;               // a transaction is in flight
	logic [IDX_W-1:0] grant;  // port owning the controller
	logic [IDX_W-1:0] pointer; // first port to consider at the next pick

	logic pick_found;
	logic [IDX_W-1:0] pick_index;
	logic [IDX_W-1:0] grant_next; // port right after the granted one

	// ####################
	// port selection
	// ####################

	// scan upwards from the pointer and wrap around
	always_comb begin
		int unsigned candidate;

		pick_found = 1'b0;
		pick_index = pointer;
		for (int k = 0; k < N_PORTS; k++) begin
			candidate = (int'(pointer) + k) % N_PORTS;
			if (!pick_found && i_request[candidate]) begin
				pick_found = 1'b1;
				pick_index = IDX_W'(candidate);
			end
		end
	end

	always_comb begin
		if (int'(grant) == N_PORTS - 1)
			grant_next = '0;
		else
			grant_next = grant + 1'b1;
	end

	// ####################
	// grant state
	// ####################

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			busy <= 1'b0;
			grant <= '0;
			pointer <= '0; // port 0 has priority after reset
		end
		else begin
			if (!busy) begin
				if (pick_found) begin
					grant <= pick_index;
					busy <= 1'b1;
				end
			end
			else if (i_mem_ready) begin
				// release for one cycle so the controller counter clears
				busy <= 1'b0;
				pointer <= grant_next;
			end
		end
	end

	// ####################
	// routing
	// ####################

	assign o_mem_request = busy; // dropped in the cycle after ready
	assign o_mem_req = i_req[grant];

	// ready goes back to the owner only
	always_comb begin
		o_ready = '0;
		if (busy && i_mem_ready)
			o_ready[grant] = 1'b1;
	end

	assign o_rsp = i_mem_rsp; // shared and read only by the port that sees its ready

endmodule

`default_nettype wire

//--- source/sram_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_params.svh"

// sequencer for an asynchronous 16-bit SRAM
// one 32-bit access runs as a low half-word and then a high half-word
// of CYCLES/2 clocks each
module sram_controller (
	input wire i_clock,
	input wire i_reset,

	// request from the arbiter
	input wire i_request,
	input wire sram_pkg::sram_req_t i_req,
	output logic o_ready,
	output sram_pkg::sram_rsp_t o_rsp,

	// SRAM pins with the data bus split into write, read and direction
	output logic [`SRAM_ADDR_WIDTH-1:0] o_sram_a,
	output logic [15:0] o_sram_d_w,
	input wire [15:0] i_sram_d_r,
	output logic o_sram_d_rw,
	output logic o_sram_ce_n,
	output logic o_sram_oe_n,
	output logic o_sram_we_n,
	output logic o_sram_lb_n,
	output logic o_sram_ub_n
);

	// ####################
	// timing constants
	// ####################

	// whole transaction length in clocks (4 at 100 MHz)
	localparam int CYCLES = (4 * `SRAM_CLOCK_HZ) / 100_000_000;
	localparam int HALF = CYCLES / 2;
	localparam int READ_OFFSET = 1;  // capture point inside a half
	localparam int WRITE_OFFSET = 1; // write strobe inside a half
	localparam int COUNT_W = $clog2(CYCLES + 2);

	logic [COUNT_W-1:0] count;
	logic [31:0] rdata; // assembled read word

	logic upper_half;
	logic do_write;
	logic do_read;
	logic lane_lo_on;
	logic lane_hi_on;

	assign upper_half = (count >= HALF);
	assign do_write = i_request && i_req.rw;
	assign do_read = i_request && !i_req.rw;

	// ####################
	// address and data
	// ####################

	always_comb begin
		// word address from the byte address with bit 0 picking the half
		o_sram_a = {i_req.address[`SRAM_ADDR_WIDTH:2], upper_half};

		if (upper_half)
			o_sram_d_w = i_req.wdata[31:16];
		else
			o_sram_d_w = i_req.wdata[15:0];
	end

	assign o_sram_d_rw = do_write; // drive the bus only for writes

	// ####################
	// control strobes
	// ####################

	assign o_sram_ce_n = !i_request; // chip selected during a transaction
	assign o_sram_oe_n = !do_read;

	always_comb begin
		o_sram_we_n = 1'b1;
		if (do_write) begin
			if (count == WRITE_OFFSET)
				o_sram_we_n = 1'b0;
			else if (count == HALF + WRITE_OFFSET)
				o_sram_we_n = 1'b0;
		end
	end

	// byte lanes follow be for writes while reads take the full half-word
	always_comb begin
		if (i_req.rw) begin
			lane_lo_on = upper_half ? i_req.be[2] : i_req.be[0];
			lane_hi_on = upper_half ? i_req.be[3] : i_req.be[1];
		end
		else begin
			lane_lo_on = 1'b1;
			lane_hi_on = 1'b1;
		end

		o_sram_lb_n = !(i_request && lane_lo_on);
		o_sram_ub_n = !(i_request && lane_hi_on);
	end

	// ####################
	// sequencing
	// ####################

	// counter runs while the request is held and clears in the idle cycle
	always_ff @(posedge i_clock) begin
		if (i_reset)
			count <= '0;
		else if (i_request)
			count <= count + 1'b1;
		else
			count <= '0;
	end

	always_ff @(posedge i_clock) begin
		if (do_read) begin
			if (count == READ_OFFSET)
				rdata[15:0] <= i_sram_d_r;
			else if (count == HALF + READ_OFFSET)
				rdata[31:16] <= i_sram_d_r;
		end
	end

	assign o_ready = i_request && (count >= CYCLES);
	assign o_rsp.rdata = rdata;

endmodule

`default_nettype wire

//--- source/sram_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_params.svh"

// two peer requesters (instruction and data) sharing one external SRAM
module sram_subsystem (
	input wire i_clock,
	input wire i_reset,

	// ####################
	// requester ports
	// ####################

	input wire [`SRAM_NUM_PORTS-1:0] i_request,
	input wire sram_pkg::sram_req_t [`SRAM_NUM_PORTS-1:0] i_req,
	output logic [`SRAM_NUM_PORTS-1:0] o_ready,
	output sram_pkg::sram_rsp_t o_rsp,

	// ####################
	// SRAM pins
	// ####################

	output logic [`SRAM_ADDR_WIDTH-1:0] o_sram_a,
	output logic [15:0] o_sram_d_w,
	input wire [15:0] i_sram_d_r,
	output logic o_sram_d_rw, // board wrapper builds the tristate from this
	output logic o_sram_ce_n,
	output logic o_sram_oe_n,
	output logic o_sram_we_n,
	output logic o_sram_lb_n,
	output logic o_sram_ub_n
);

	// arbiter to controller
	logic mem_request;
	sram_pkg::sram_req_t mem_req;
	logic mem_ready;
	sram_pkg::sram_rsp_t mem_rsp;

	sram_arbiter #(
		.N_PORTS(`SRAM_NUM_PORTS)
	) u_arbiter (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_req(i_req),
		.o_ready(o_ready),
		.o_rsp(o_rsp),
		.o_mem_request(mem_request),
		.o_mem_req(mem_req),
		.i_mem_ready(mem_ready),
		.i_mem_rsp(mem_rsp)
	);

	sram_controller u_controller (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(mem_request),
		.i_req(mem_req),
		.o_ready(mem_ready),
		.o_rsp(mem_rsp),
		.o_sram_a(o_sram_a),
		.o_sram_d_w(o_sram_d_w),
		.i_sram_d_r(i_sram_d_r),
		.o_sram_d_rw(o_sram_d_rw),
		.o_sram_ce_n(o_sram_ce_n),
		.o_sram_oe_n(o_sram_oe_n),
		.o_sram_we_n(o_sram_we_n),
		.o_sram_lb_n(o_sram_lb_n),
		.o_sram_ub_n(o_sram_ub_n)
	);

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// free-running clock and power-on reset
module tb_clock_gen #(
	parameter int PERIOD_NS = 8,
	parameter int RESET_CYCLES = 5
)(
	output logic o_clock,
	output logic o_reset
);

	initial begin
		o_clock = 1'b0;
		forever #(PERIOD_NS / 2.0) o_clock = ~o_clock;
	end

	initial begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clock);
		#1 o_reset = 1'b0; // released in step with the other stimulus
	end

endmodule

`default_nettype wire

//--- tb/sram_model.sv
`timescale 1ns/1ps
`default_nettype none

// asynchronous 16-bit SRAM with two byte lanes
module sram_model #(
	parameter int ADDR_WIDTH = 18
)(
	input wire [ADDR_WIDTH-1:0] i_a,
	input wire [15:0] i_d_w,
	output logic [15:0] o_d_r,
	input wire i_d_rw, // bus driven by the controller
	input wire i_ce_n,
	input wire i_oe_n,
	input wire i_we_n,
	input wire i_lb_n,
	input wire i_ub_n
);

	localparam int DEPTH = 1 << ADDR_WIDTH;

	logic [15:0] mem [0:DEPTH-1];

	// power-up contents with every address bit folded in
	initial begin
		for (int a = 0; a < DEPTH; a++)
			mem[a] = 16'(a) ^ 16'(a >> 16) ^ 16'h5a5a;
	end

	// lanes are written a moment into the write pulse once the pins have settled
	always @(negedge i_we_n) begin
		#2;
		if (!i_we_n && !i_ce_n && i_d_rw) begin
			if (!i_lb_n)
				mem[i_a][7:0] = i_d_w[7:0];
			if (!i_ub_n)
				mem[i_a][15:8] = i_d_w[15:8];
		end
	end

	assign o_d_r = (!i_ce_n && !i_oe_n) ? mem[i_a] : 16'h0000; // flow-through read

endmodule

`default_nettype wire

//--- tb/tb_sram_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_params.svh"

module tb_sram_subsystem;

	localparam int NUM_PORTS = `SRAM_NUM_PORTS;
	localparam int CLOCK_PERIOD_NS = 8;
	localparam int RESET_CYCLES = 5;
	localparam int IDLE_CYCLES = 4;    // quiet time after reset
	localparam int BURST_PER_PORT = 3; // writes followed by as many reads
	localparam int PRELOAD_WORDS = 64; // test window
	localparam int WORDS_PER_PORT = PRELOAD_WORDS / NUM_PORTS;
	localparam int OFFSET_W = $clog2(WORDS_PER_PORT);
	localparam int PARTIAL_STEPS = 5;
	localparam int RANDOM_PER_PORT = 100;
	localparam int NUM_TRANSFERS = 2 * NUM_PORTS * BURST_PER_PORT + PRELOAD_WORDS + 4
		+ 2 * PARTIAL_STEPS + NUM_PORTS * RANDOM_PER_PORT;
	localparam int TIMEOUT_NS = (NUM_TRANSFERS * 12 + RESET_CYCLES + IDLE_CYCLES)
		* CLOCK_PERIOD_NS;

	logic clock;
	logic reset;
	logic [NUM_PORTS-1:0] request;
	sram_pkg::sram_req_t [NUM_PORTS-1:0] req_bus;
	logic [NUM_PORTS-1:0] ready;
	sram_pkg::sram_rsp_t rsp;

	logic [`SRAM_ADDR_WIDTH-1:0] sram_a;
	logic [15:0] sram_d_w;
	logic [15:0] sram_d_r;
	logic sram_d_rw;
	logic sram_ce_n;
	logic sram_oe_n;
	logic sram_we_n;
	logic sram_lb_n;
	logic sram_ub_n;

	// ####################
	// checker state
	// ####################

	logic [31:0] shadow [0:PRELOAD_WORDS-1];
	logic [NUM_PORTS-1:0] exp_read;          // a read is outstanding
	logic [31:0] exp_rdata [0:NUM_PORTS-1];
	logic [4:0] age [0:NUM_PORTS-1];         // edges that sampled the request
	logic [NUM_PORTS-1:0] next_onehot;       // round-robin turn
	logic first_request_sent;
	logic solo_mode;
	logic contend_mode;
	logic [15:0] lfsr_state;
	int error_count;
	int transfer_count;
	sram_pkg::sram_req_t rnd_op [0:NUM_PORTS-1][0:RANDOM_PER_PORT-1];

	logic [NUM_PORTS+3:0] idle_pins;
	assign idle_pins = {ready, sram_ce_n, sram_oe_n, sram_we_n, sram_d_rw};

	tb_clock_gen #(
		.PERIOD_NS(CLOCK_PERIOD_NS),
		.RESET_CYCLES(RESET_CYCLES)
	) u_clock_gen (
		.o_clock(clock),
		.o_reset(reset)
	);

	sram_subsystem DUT (
		.i_clock(clock),
		.i_reset(reset),
		.i_request(request),
		.i_req(req_bus),
		.o_ready(ready),
		.o_rsp(rsp),
		.o_sram_a(sram_a),
		.o_sram_d_w(sram_d_w),
		.i_sram_d_r(sram_d_r),
		.o_sram_d_rw(sram_d_rw),
		.o_sram_ce_n(sram_ce_n),
		.o_sram_oe_n(sram_oe_n),
		.o_sram_we_n(sram_we_n),
		.o_sram_lb_n(sram_lb_n),
		.o_sram_ub_n(sram_ub_n)
	);

	sram_model #(
		.ADDR_WIDTH(`SRAM_ADDR_WIDTH)
	) u_sram (
		.i_a(sram_a),
		.i_d_w(sram_d_w),
		.o_d_r(sram_d_r),
		.i_d_rw(sram_d_rw),
		.i_ce_n(sram_ce_n),
		.i_oe_n(sram_oe_n),
		.i_we_n(sram_we_n),
		.i_lb_n(sram_lb_n),
		.i_ub_n(sram_ub_n)
	);

	// priority moves to the port after the one just served
	always @(posedge clock) begin
		if (reset)
			next_onehot <= NUM_PORTS'(1);
		else if (ready != '0)
			next_onehot <= {next_onehot[NUM_PORTS-2:0], next_onehot[NUM_PORTS-1]};
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (reset || !request[p] || ready[p])
				age[p] <= '0;
			else
				age[p] <= age[p] + 1'b1;
		end
	end

	// ####################
	// assertions
	// ####################

	assert property (@(posedge clock) disable iff (reset)
		!first_request_sent |-> (idle_pins == {NUM_PORTS'(0), 4'b1110}))
	else begin
		error_count++;
		$display("[FAIL] idle pins {o_ready,ce_n,oe_n,we_n,d_rw} expected %h got %h",
			{NUM_PORTS'(0), 4'b1110}, $sampled(idle_pins));
	end

	assert property (@(posedge clock) disable iff (reset) $onehot0(ready))
	else begin
		error_count++;
		$display("[FAIL] o_ready expected one-hot or zero got %h", $sampled(ready));
	end

	assert property (@(posedge clock) disable iff (reset)
		(contend_mode && ready != '0) |-> (ready == next_onehot))
	else begin
		error_count++;
		$display("[FAIL] o_ready expected %h got %h", $sampled(next_onehot), $sampled(ready));
	end

	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port_checks
		assert property (@(posedge clock) disable iff (reset)
			(ready[p] && exp_read[p]) |-> (rsp.rdata == exp_rdata[p]))
		else begin
			error_count++;
			$display("[FAIL] o_rsp.rdata port %0d expected %h got %h", p,
				$sampled(exp_rdata[p]), $sampled(rsp.rdata));
		end

		// uncontended ready comes on the fifth sampled cycle
		assert property (@(posedge clock) disable iff (reset)
			(solo_mode && request[p]) |-> (ready[p] == (age[p] == 5)))
		else begin
			error_count++;
			$display("[FAIL] o_ready[%0d] expected %h got %h", p,
				$sampled(age[p] == 5), $sampled(ready[p]));
		end

		assert property (@(posedge clock) disable iff (reset) ready[p] |=> !ready[p])
		else begin
			error_count++;
			$display("[FAIL] o_ready[%0d] expected %h got %h", p, 1'b0, $sampled(ready[p]));
		end
	end

	// ####################
	// helpers
	// ####################

	// galois LFSR stepped once per bit taken
	function automatic logic [31:0] lfsr_bits(input int count);
		logic [31:0] value;
		logic out_bit;
		value = '0;
		for (int i = 0; i < count; i++) begin
			out_bit = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (out_bit)
				lfsr_state = lfsr_state ^ 16'hb400;
			value = {value[30:0], out_bit};
		end
		return value;
	endfunction

	function automatic sram_pkg::sram_req_t make_req(input logic rw, input int unsigned word,
			input logic [31:0] data, input logic [3:0] be);
		sram_pkg::sram_req_t req;
		req.rw = rw;
		req.address = 32'(word) << 2;
		req.wdata = data;
		req.be = be;
		return req;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
			input logic [31:0] new_word, input logic [3:0] be);
		logic [31:0] merged;
		merged = old_word;
		for (int b = 0; b < 4; b++) begin
			if (be[b])
				merged[8*b +: 8] = new_word[8*b +: 8];
		end
		return merged;
	endfunction

	// one request on one port held until its ready strobe
	task automatic transfer(input int port, input sram_pkg::sram_req_t req);
		int unsigned word;
		logic seen;
		word = 32'(req.address[7:2]);
		@(posedge clock);
		#1;
		if (!req.rw) begin
			exp_rdata[port] = shadow[word];
			exp_read[port] = 1'b1;
		end
		req_bus[port] = req;
		request[port] = 1'b1;
		first_request_sent = 1'b1;
		seen = 1'b0;
		while (!seen) begin
			@(posedge clock);
			seen = ready[port];
		end
		#1;
		request[port] = 1'b0; // low for at least one cycle
		exp_read[port] = 1'b0;
		if (req.rw)
			shadow[word] = merge_bytes(shadow[word], req.wdata, req.be);
		transfer_count++;
	endtask

	task automatic write_read_burst(input int port);
		int unsigned base;
		base = port * WORDS_PER_PORT;
		for (int k = 0; k < BURST_PER_PORT; k++)
			transfer(port, make_req(1'b1, base + k, 32'hc0de_0000 + 32'(port * 256 + k), 4'hf));
		for (int k = 0; k < BURST_PER_PORT; k++)
			transfer(port, make_req(1'b0, base + k, '0, 4'h0));
	endtask

	task automatic replay_random_ops(input int port);
		for (int k = 0; k < RANDOM_PER_PORT; k++)
			transfer(port, rnd_op[port][k]);
	endtask

	// ####################
	// stimulus
	// ####################

	initial begin
		logic [31:0] data;
		logic [3:0] be;
		logic rw;
		logic [OFFSET_W-1:0] offset;
		logic [3:0] partial_be [0:PARTIAL_STEPS-1];

		request = '0;
		req_bus = '0;
		exp_read = '0;
		first_request_sent = 1'b0;
		solo_mode = 1'b0;
		contend_mode = 1'b0;
		error_count = 0;
		transfer_count = 0;
		lfsr_state = 16'd47723;
		partial_be = '{4'b0001, 4'b0110, 4'b1000, 4'b1010, 4'b0000};
		for (int p = 0; p < NUM_PORTS; p++)
			exp_rdata[p] = '0;

		// each port keeps to its own half of the window
		for (int p = 0; p < NUM_PORTS; p++) begin
			for (int k = 0; k < RANDOM_PER_PORT; k++) begin
				rw = 1'(lfsr_bits(1));
				offset = OFFSET_W'(lfsr_bits(OFFSET_W));
				data = lfsr_bits(32);
				be = 4'(lfsr_bits(4));
				rnd_op[p][k] = make_req(rw, p * WORDS_PER_PORT + offset, data, be);
			end
		end

		@(negedge reset);
		repeat (IDLE_CYCLES) @(posedge clock);

		// both ports from the first pick after reset
		contend_mode = 1'b1;
		fork
			write_read_burst(0);
			write_read_burst(1);
		join
		contend_mode = 1'b0;

		solo_mode = 1'b1;
		for (int w = 0; w < PRELOAD_WORDS; w++) begin
			data = lfsr_bits(32);
			transfer(0, make_req(1'b1, w, data, 4'hf));
		end

		data = lfsr_bits(32);
		transfer(0, make_req(1'b1, 5, data, 4'hf));
		transfer(0, make_req(1'b0, 5, '0, 4'h0));
		data = lfsr_bits(32);
		transfer(1, make_req(1'b1, 40, data, 4'hf));
		transfer(1, make_req(1'b0, 40, '0, 4'h0));

		for (int s = 0; s < PARTIAL_STEPS; s++) begin
			data = lfsr_bits(32);
			transfer(0, make_req(1'b1, 9, data, partial_be[s]));
			transfer(0, make_req(1'b0, 9, '0, 4'h0));
		end
		solo_mode = 1'b0;

		fork
			replay_random_ops(0);
			replay_random_ops(1);
		join

		repeat (2) @(posedge clock);
		$display("checks done: %0d transfers, %0d errors", transfer_count, error_count);
		if (error_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the run did not finish within %0d ns, a request never got ready",
			TIMEOUT_NS);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+source
source/sram_pkg.sv
source/sram_arbiter.sv
source/sram_controller.sv
source/sram_subsystem.sv
tb/tb_clock_gen.sv
tb/sram_model.sv
tb/tb_sram_subsystem.sv

//--- Bender.yml
package:
  name: sram_subsystem

sources:
  # design
  - include_dirs:
      - source
    files:
      - source/sram_pkg.sv
      - source/sram_arbiter.sv
      - source/sram_controller.sv
      - source/sram_subsystem.sv

  # testbench
  - target: test
    include_dirs:
      - source
    files:
      - tb/tb_clock_gen.sv
      - tb/sram_model.sv
      - tb/tb_sram_subsystem.sv
